/* sim.f */
hw/feeder_map_pkg.sv
hw/feeder_types_pkg.sv
hw/bus_reg_decode.sv
hw/line_request_gen.sv
hw/line_word_loader.sv
hw/data_feeder_top.sv
sim/tb_data_feeder.sv

/* Bender.yml */
package:
  name: data_feeder

sources:
  - files:
      - hw/feeder_map_pkg.sv
      - hw/feeder_types_pkg.sv
      - hw/bus_reg_decode.sv
      - hw/line_request_gen.sv
      - hw/line_word_loader.sv
      - hw/data_feeder_top.sv

  - target: simulation
    files:
      - sim/tb_data_feeder.sv

/* sim/feeder_stim.txt */
// columns: start byte address, length in words, kind (0 input, 1 weight),
// start index, cycles the request full flag is held; a zero length ends the list
00001000 0020 0 0000 00
00001006 0005 1 0010 03
0000203e 0001 0 0100 00
0000203e 0002 1 0020 02
00003010 0040 0 0040 08
00004000 0021 1 0000 00
0001fff0 0030 0 0200 05
00005002 001f 1 0007 01
00006000 0080 0 0300 10
0000707e 0003 1 0011 00
00008020 0010 0 7ff8 04
00009ffc 0064 1 0050 00
0000a000 0001 1 0000 00
0000b00a 0017 0 0123 06
0000c03c 0022 1 0001 02
12345640 0020 0 0000 00
0000d000 00c8 0 0400 00
0000e012 000e 1 0066 03
0000f03e 0041 0 0000 07
00010000 0002 1 0abc 01
00000000 0000 0 0000 00

/* sim/tb_data_feeder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_data_feeder;

    localparam int LEN_BITS  = 15;
    localparam int MAX_XFERS = 64;
    localparam int XW        = feeder_map_pkg::XLEN;
    localparam int LW        = feeder_map_pkg::LINE_W;
    localparam int WW        = feeder_map_pkg::WORD_W;

    logic                       clk_i;
    logic                       rst_i;
    feeder_types_pkg::bus_req_t bus_req;
    feeder_types_pkg::bus_rsp_t bus_rsp;
    logic                       req_full_i;
    logic                       req_valid_o;
    logic [XW-1:0]              req_addr_o;
    logic                       line_empty_i;
    logic [LW-1:0]              line_data_i;
    logic                       line_pop_o;
    feeder_types_pkg::tpu_cmd_t tpu_cmd_o;
    logic                       tpu_busy_i;

    integer                     seed;
    logic [XW-1:0]              stim_mem [0:5*MAX_XFERS-1];
    int                         stim_words;
    logic                       stim_loaded;
    logic [WW-1:0]              cfg_idx;

    // DRAM line FIFO and expected traffic
    logic [LW-1:0]              lines [$];
    logic [XW-1:0]              exp_reqs [$];
    feeder_types_pkg::tpu_cmd_t exp_cmds [$];

    data_feeder_top #(
        .LEN_BITS (LEN_BITS)
    ) dut0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_i        (bus_req),
        .bus_o        (bus_rsp),
        .req_full_i   (req_full_i),
        .req_valid_o  (req_valid_o),
        .req_addr_o   (req_addr_o),
        .line_empty_i (line_empty_i),
        .line_data_i  (line_data_i),
        .line_pop_o   (line_pop_o),
        .tpu_cmd_o    (tpu_cmd_o),
        .tpu_busy_i   (tpu_busy_i)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #4;
            clk_i = ~clk_i;
        end
    end

    // ########################################
    // checks
    // ########################################

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_cmd(input feeder_types_pkg::tpu_cmd_t got,
                             input feeder_types_pkg::tpu_cmd_t exp);
        if (got !== exp) begin
            abort_run($sformatf({"Error at %0d ns: command v=%0b op=%0d w=%h i=%h, ",
                                 "expected v=%0b op=%0d w=%h i=%h"}, $time,
                                got.valid, got.op, got.param_1, got.param_2,
                                exp.valid, exp.op, exp.param_1, exp.param_2));
        end
    endtask

    task automatic check_addr(input logic [XW-1:0] got, input logic [XW-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0d ns: request address %h, expected %h",
                                $time, got, exp));
        end
    endtask

    task automatic check_rsp(input feeder_types_pkg::bus_rsp_t got,
                             input feeder_types_pkg::bus_rsp_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Error at %0d ns: bus ready=%0b rdata=%h, expected %0b %h",
                                $time, got.ready, got.rdata, exp.ready, exp.rdata));
        end
    endtask

    // word at byte address a holds a bits 16:1
    function automatic logic [LW-1:0] line_for(input logic [XW-1:0] addr);
        logic [LW-1:0] line;
        logic [XW-1:0] a;
        int            j;
        for (j = 0; j < feeder_map_pkg::LINE_WORDS; j++) begin
            a = {addr[XW-1:6], 6'b0} + XW'(2 * j);
            line[j*WW +: WW] = a[16:1];
        end
        return line;
    endfunction

    // ########################################
    // bus accesses
    // ########################################

    task automatic bus_access(input logic rw, input logic [XW-1:0] addr,
                              input logic [XW-1:0] wdata, input logic [XW-1:0] exp_rdata,
                              input logic cmd_due);
        feeder_types_pkg::bus_rsp_t exp;
        bus_req.strobe = 1'b1;
        bus_req.rw     = rw;
        bus_req.addr   = addr;
        bus_req.wdata  = wdata;
        @(negedge clk_i);
        bus_req   = '0;
        exp.ready = 1'b1;
        exp.rdata = exp_rdata;
        check_rsp(bus_rsp, exp);
        if (cmd_due && tpu_cmd_o.valid !== 1'b1) begin
            abort_run("direct command did not appear one cycle after its write");
        end
        // response lasts exactly one cycle
        @(negedge clk_i);
        exp = '0;
        check_rsp(bus_rsp, exp);
    endtask

    task automatic reg_write(input logic [XW-1:0] addr, input logic [XW-1:0] wdata);
        bus_access(1'b1, addr, wdata, '0, 1'b0);
    endtask

    task automatic busy_read(input logic [XW-1:0] exp_rdata);
        bus_access(1'b0, feeder_map_pkg::REG_BUSY, '0, exp_rdata, 1'b0);
    endtask

    task automatic direct_cmd(input logic [XW-1:0] wdata);
        feeder_types_pkg::tpu_cmd_t exp;
        exp.valid   = 1'b1;
        exp.op      = feeder_types_pkg::tpu_op_e'(wdata[7:0]);
        exp.param_1 = wdata[XW-1 -: WW];
        exp.param_2 = cfg_idx;
        exp_cmds.push_back(exp);
        bus_access(1'b1, feeder_map_pkg::REG_CMD, wdata, '0, 1'b1);
    endtask

    task automatic run_transfer(input logic [XW-1:0] addr, input int len, input logic kind,
                                input logic [WW-1:0] idx, input int stall);
        feeder_types_pkg::tpu_cmd_t exp;
        logic [XW-1:0]              a;
        logic [XW-1:0]              last_byte;
        int                         i;
        // one request for each line the words touch
        last_byte = addr + XW'(2 * len - 1);
        a         = addr;
        exp_reqs.push_back(a);
        while (a[XW-1:6] != last_byte[XW-1:6]) begin
            a = {a[XW-1:6] + 1'b1, 6'b0};
            exp_reqs.push_back(a);
        end
        for (i = 0; i < len; i++) begin
            a           = addr + XW'(2 * i);
            exp.valid   = 1'b1;
            exp.op      = kind ? feeder_types_pkg::OP_LOAD_WEIGHT
                               : feeder_types_pkg::OP_LOAD_INPUT;
            exp.param_1 = a[16:1];
            exp.param_2 = WW'((idx + i) % (1 << LEN_BITS));
            exp_cmds.push_back(exp);
        end
        reg_write(feeder_map_pkg::REG_RD_ADDR, addr);
        reg_write(feeder_map_pkg::REG_RD_LEN, len);
        reg_write(feeder_map_pkg::REG_KIND, kind);
        reg_write(feeder_map_pkg::REG_SRAM_IDX, idx);
        cfg_idx = idx;
        if (stall > 0) begin
            req_full_i = 1'b1;
        end
        reg_write(feeder_map_pkg::REG_TR, 32'h1);
        busy_read(32'h1);
        repeat (stall) @(negedge clk_i);
        req_full_i = 1'b0;
        // drained once every request, word and line has gone through
        while (exp_cmds.size() != 0 || exp_reqs.size() != 0 || lines.size() != 0) begin
            @(negedge clk_i);
        end
        busy_read(32'h0);
    endtask

    // ########################################
    // DRAM side and command monitor
    // ########################################

    initial begin : line_side_monitor
        logic          full_seen;
        logic          push_pend;
        logic [XW-1:0] push_addr;
        logic          pop_pend;
        logic          gap;
        push_pend = 1'b0;
        pop_pend  = 1'b0;
        push_addr = '0;
        forever begin
            @(posedge clk_i);
            full_seen = req_full_i;
            @(negedge clk_i);
            // requests and pops seen last cycle were taken at this posedge
            if (push_pend) begin
                lines.push_back(line_for(push_addr));
            end
            if (pop_pend) begin
                if (lines.size() == 0) begin
                    abort_run("line FIFO popped while it was empty");
                end
                lines.delete(0);
            end
            push_pend = 1'b0;
            pop_pend  = (line_pop_o === 1'b1);
            if (req_valid_o === 1'b1) begin
                if (full_seen) begin
                    abort_run("line request issued right after the full flag was high");
                end
                if (exp_reqs.size() == 0) begin
                    abort_run("line request issued when none was expected");
                end
                check_addr(req_addr_o, exp_reqs.pop_front());
                push_pend = 1'b1;
                push_addr = req_addr_o;
            end
            if (tpu_cmd_o.valid === 1'b1) begin
                if (exp_cmds.size() == 0) begin
                    abort_run("accelerator command issued when none was expected");
                end
                check_cmd(tpu_cmd_o, exp_cmds.pop_front());
            end
            // random gaps in line availability outside pops
            gap          = (($random(seed) & 3) == 0) && !pop_pend;
            line_empty_i = (lines.size() == 0) || gap;
            line_data_i  = (lines.size() == 0) ? '0 : lines[0];
        end
    end

    initial begin : watchdog
        wait (stim_loaded === 1'b1);
        repeat (200 * stim_words + 1000) @(posedge clk_i);
        abort_run("watchdog expired before the tests finished");
    end

    // ########################################
    // main sequence
    // ########################################

    initial begin : main_sequence
        int n;
        int t;
        rst_i        = 1'b1;
        bus_req      = '0;
        req_full_i   = 1'b0;
        line_empty_i = 1'b1;
        line_data_i  = '0;
        tpu_busy_i   = 1'b0;
        cfg_idx      = '0;
        seed         = 32'h244d_86b3;
        stim_loaded  = 1'b0;
        stim_words   = 0;
        for (n = 0; n < 5 * MAX_XFERS; n++) begin
            stim_mem[n] = '0;
        end
        $readmemh("sim/feeder_stim.txt", stim_mem);
        n = 0;
        while (n < MAX_XFERS && stim_mem[5*n+1] != 0) begin
            stim_words = stim_words + stim_mem[5*n+1];
            n++;
        end
        stim_loaded = 1'b1;
        if (n == 0) begin
            abort_run("no transfers found in sim/feeder_stim.txt");
        end
        repeat (8) @(negedge clk_i);
        rst_i = 1'b0;
        @(negedge clk_i);

        // idle busy flag follows the accelerator
        busy_read(32'h0);
        tpu_busy_i = 1'b1;
        busy_read(32'h1);
        tpu_busy_i = 1'b0;
        busy_read(32'h0);
        direct_cmd(32'hbeef_0005);
        direct_cmd(32'h0042_0009);

        for (t = 0; t < n; t++) begin
            run_transfer(stim_mem[5*t], stim_mem[5*t+1], stim_mem[5*t+2][0],
                         stim_mem[5*t+3][WW-1:0], stim_mem[5*t+4]);
            if (t == 3) begin
                direct_cmd(32'h5a5a_00c3);
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/data_feeder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module data_feeder_top #(
    parameter int LEN_BITS = 15
) (
    input  wire                               clk_i,
    input  wire                               rst_i,
    input  wire feeder_types_pkg::bus_req_t   bus_i,
    output feeder_types_pkg::bus_rsp_t        bus_o,
    input  wire                               req_full_i,
    output logic                              req_valid_o,
    output logic [feeder_map_pkg::XLEN-1:0]   req_addr_o,
    input  wire                               line_empty_i,
    input  wire [feeder_map_pkg::LINE_W-1:0]  line_data_i,
    output logic                              line_pop_o,
    output feeder_types_pkg::tpu_cmd_t        tpu_cmd_o,
    input  wire                               tpu_busy_i
);

    feeder_types_pkg::xfer_cfg_t cfg;
    feeder_types_pkg::tpu_cmd_t  direct_cmd;
    logic                        start;
    logic                        req_busy;
    logic                        load_busy;

    // ########################################
    // register decode
    // ########################################

    bus_reg_decode #(
        .LEN_BITS (LEN_BITS)
    ) u_decode (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bus_i        (bus_i),
        .bus_o        (bus_o),
        .cfg_o        (cfg),
        .start_o      (start),
        .direct_cmd_o (direct_cmd),
        .req_busy_i   (req_busy),
        .load_busy_i  (load_busy),
        .tpu_busy_i   (tpu_busy_i)
    );

    // ########################################
    // request and load engines
    // ########################################

    line_request_gen #(
        .LEN_BITS (LEN_BITS)
    ) u_req (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (start),
        .cfg_i       (cfg),
        .req_full_i  (req_full_i),
        .req_valid_o (req_valid_o),
        .req_addr_o  (req_addr_o),
        .busy_o      (req_busy)
    );

    line_word_loader #(
        .LEN_BITS (LEN_BITS)
    ) u_load (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_i      (start),
        .cfg_i        (cfg),
        .direct_cmd_i (direct_cmd),
        .line_empty_i (line_empty_i),
        .line_data_i  (line_data_i),
        .line_pop_o   (line_pop_o),
        .tpu_cmd_o    (tpu_cmd_o),
        .busy_o       (load_busy)
    );

endmodule

`default_nettype wire

/* hw/line_word_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module line_word_loader #(
    parameter int LEN_BITS = 15
) (
    input  wire                                clk_i,
    input  wire                                rst_i,
    input  wire                                start_i,
    input  wire feeder_types_pkg::xfer_cfg_t   cfg_i,
    input  wire feeder_types_pkg::tpu_cmd_t    direct_cmd_i,
    input  wire                                line_empty_i,
    input  wire [feeder_map_pkg::LINE_W-1:0]   line_data_i,
    output logic                               line_pop_o,
    output feeder_types_pkg::tpu_cmd_t         tpu_cmd_o,
    output logic                               busy_o
);

    localparam int WW  = feeder_map_pkg::WORD_W;
    localparam int OFS = feeder_map_pkg::LINE_OFS_W;
    localparam int SEL = feeder_map_pkg::WORD_SEL_W;

    feeder_types_pkg::load_state_e   state_q;
    feeder_types_pkg::load_state_e   state_d;
    logic [feeder_map_pkg::LINE_W-1:0] line_q;
    logic [SEL-1:0]                  sel_q;
    logic [LEN_BITS-1:0]             sent_q;
    logic [LEN_BITS-1:0]             idx_q;
    feeder_types_pkg::word_kind_e    kind_q;
    logic [LEN_BITS-1:0]             len;
    logic                            launch;
    logic                            emit_go;
    logic                            last_word;
    logic [WW-1:0]                   word;
    feeder_types_pkg::tpu_op_e       word_op;

    assign len     = cfg_i.len[LEN_BITS-1:0];
    assign launch  = start_i && (len != '0);
    // a direct command holds word emission for that cycle
    assign emit_go = (state_q == feeder_types_pkg::LD_EMIT) && !direct_cmd_i.valid;
    assign last_word = (sel_q == '1) || (sent_q == len - 1'b1);

    always_comb begin
        state_d = state_q;
        case (state_q)
            feeder_types_pkg::LD_IDLE: begin
                if (launch) begin
                    state_d = feeder_types_pkg::LD_WAIT_LINE;
                end
            end
            feeder_types_pkg::LD_WAIT_LINE: begin
                if (!line_empty_i) begin
                    state_d = feeder_types_pkg::LD_EMIT;
                end
            end
            feeder_types_pkg::LD_EMIT: begin
                if (emit_go && last_word) begin
                    state_d = feeder_types_pkg::LD_POP;
                end
            end
            default: begin
                // pop state, counter already holds the words sent
                state_d = (sent_q == len) ? feeder_types_pkg::LD_IDLE
                                          : feeder_types_pkg::LD_WAIT_LINE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= feeder_types_pkg::LD_IDLE;
            sent_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == feeder_types_pkg::LD_IDLE && launch) begin
                sent_q <= '0;
            end else if (emit_go) begin
                sent_q <= sent_q + 1'b1;
            end
        end
    end

    // word pointer from byte address bits 5:1, wraps at the line end
    always_ff @(posedge clk_i) begin
        if (state_q == feeder_types_pkg::LD_IDLE && launch) begin
            sel_q  <= cfg_i.addr[OFS-1:1];
            idx_q  <= cfg_i.idx[LEN_BITS-1:0];
            kind_q <= cfg_i.kind;
        end else if (emit_go) begin
            sel_q <= sel_q + 1'b1;
            idx_q <= idx_q + 1'b1;
        end
    end

    // head line of the FIFO
    always_ff @(posedge clk_i) begin
        if (state_q == feeder_types_pkg::LD_WAIT_LINE && !line_empty_i) begin
            line_q <= line_data_i;
        end
    end

    assign word    = line_q[sel_q*WW +: WW];
    assign word_op = (kind_q == feeder_types_pkg::KIND_WEIGHT) ?
                     feeder_types_pkg::OP_LOAD_WEIGHT : feeder_types_pkg::OP_LOAD_INPUT;

    always_comb begin
        if (direct_cmd_i.valid) begin
            tpu_cmd_o = direct_cmd_i;
        end else begin
            tpu_cmd_o.valid   = emit_go;
            tpu_cmd_o.op      = word_op;
            tpu_cmd_o.param_1 = word;
            tpu_cmd_o.param_2 = WW'(idx_q);
        end
    end

    assign line_pop_o = (state_q == feeder_types_pkg::LD_POP);
    assign busy_o     = (state_q != feeder_types_pkg::LD_IDLE);

    // the popped line is the one captured earlier, so the FIFO still holds it
    a_pop_not_empty: assert property (
        @(posedge clk_i) disable iff (rst_i) line_pop_o |-> !line_empty_i
    );

endmodule

`default_nettype wire

/* hw/line_request_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module line_request_gen #(
    parameter int LEN_BITS = 15
) (
    input  wire                               clk_i,
    input  wire                               rst_i,
    input  wire                               start_i,
    input  wire feeder_types_pkg::xfer_cfg_t  cfg_i,
    input  wire                               req_full_i,
    output logic                              req_valid_o,
    output logic [feeder_map_pkg::XLEN-1:0]   req_addr_o,
    output logic                              busy_o
);

    localparam int OFS = feeder_map_pkg::LINE_OFS_W;
    localparam int XW  = feeder_map_pkg::XLEN;

    feeder_types_pkg::req_state_e state_q;
    feeder_types_pkg::req_state_e state_d;
    logic [XW-1:0]                addr_q;
    logic [LEN_BITS:0]            cnt_q;
    logic [OFS-1:0]               remain;
    logic [LEN_BITS:0]            cnt_next;
    logic                         last_req;
    logic                         launch;

    // words left in the current line (1 to 32)
    assign remain   = OFS'(feeder_map_pkg::LINE_WORDS) - OFS'(addr_q[OFS-1:1]);
    assign cnt_next = cnt_q + (LEN_BITS+1)'(remain);
    assign last_req = cnt_next >= {1'b0, cfg_i.len[LEN_BITS-1:0]};
    assign launch   = start_i && (cfg_i.len[LEN_BITS-1:0] != '0);

    always_comb begin
        state_d = state_q;
        case (state_q)
            feeder_types_pkg::REQ_IDLE: begin
                if (launch) begin
                    state_d = feeder_types_pkg::REQ_WAIT;
                end
            end
            feeder_types_pkg::REQ_WAIT: begin
                if (!req_full_i) begin
                    state_d = feeder_types_pkg::REQ_SEND;
                end
            end
            feeder_types_pkg::REQ_SEND: begin
                state_d = last_req ? feeder_types_pkg::REQ_IDLE : feeder_types_pkg::REQ_WAIT;
            end
            default: begin
                state_d = feeder_types_pkg::REQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= feeder_types_pkg::REQ_IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == feeder_types_pkg::REQ_IDLE && launch) begin
                cnt_q <= '0;
            end else if (state_q == feeder_types_pkg::REQ_SEND) begin
                cnt_q <= cnt_next;
            end
        end
    end

    // first request at the start address and later ones on line boundaries
    always_ff @(posedge clk_i) begin
        if (state_q == feeder_types_pkg::REQ_IDLE && launch) begin
            addr_q <= cfg_i.addr;
        end else if (state_q == feeder_types_pkg::REQ_SEND) begin
            addr_q <= {addr_q[XW-1:OFS] + 1'b1, {OFS{1'b0}}};
        end
    end

    assign req_valid_o = (state_q == feeder_types_pkg::REQ_SEND);
    assign req_addr_o  = addr_q;
    assign busy_o      = (state_q != feeder_types_pkg::REQ_IDLE);

    // no request once the requested words cover the length
    a_no_req_past_len: assert property (
        @(posedge clk_i) disable iff (rst_i)
        req_valid_o |-> (cnt_q < {1'b0, cfg_i.len[LEN_BITS-1:0]})
    );

endmodule

`default_nettype wire

/* hw/bus_reg_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_reg_decode #(
    parameter int LEN_BITS = 15
) (
    input  wire                            clk_i,
    input  wire                            rst_i,
    input  wire feeder_types_pkg::bus_req_t bus_i,
    output feeder_types_pkg::bus_rsp_t     bus_o,
    output feeder_types_pkg::xfer_cfg_t    cfg_o,
    output logic                           start_o,
    output feeder_types_pkg::tpu_cmd_t     direct_cmd_o,
    input  wire                            req_busy_i,
    input  wire                            load_busy_i,
    input  wire                            tpu_busy_i
);

    localparam int FIELD_W = feeder_types_pkg::CFG_FIELD_W;
    localparam int WW      = feeder_map_pkg::WORD_W;
    localparam int XW      = feeder_map_pkg::XLEN;

    logic                         wr_en;
    logic                         rd_en;
    logic                         busy;
    feeder_types_pkg::xfer_cfg_t  cfg_q;
    logic                         ready_q;
    logic [XW-1:0]                rdata_q;
    logic                         cmd_valid_q;
    feeder_types_pkg::tpu_op_e    cmd_op_q;
    logic [WW-1:0]                cmd_p1_q;
    logic [WW-1:0]                cmd_p2_q;

    assign wr_en = bus_i.strobe && bus_i.rw;
    assign rd_en = bus_i.strobe && !bus_i.rw;

    // start pulse counts as busy until the engines leave idle
    assign busy = tpu_busy_i || req_busy_i || load_busy_i || start_o;

    // ########################################
    // transfer config
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            case (bus_i.addr)
                feeder_map_pkg::REG_RD_ADDR: begin
                    cfg_q.addr <= bus_i.wdata;
                end
                feeder_map_pkg::REG_RD_LEN: begin
                    cfg_q.len <= FIELD_W'(bus_i.wdata[LEN_BITS-1:0]);
                end
                feeder_map_pkg::REG_KIND: begin
                    cfg_q.kind <= feeder_types_pkg::word_kind_e'(bus_i.wdata[0]);
                end
                feeder_map_pkg::REG_SRAM_IDX: begin
                    cfg_q.idx <= FIELD_W'(bus_i.wdata[LEN_BITS-1:0]);
                end
                default: begin
                end
            endcase
        end
    end

    assign cfg_o = cfg_q;

    // ########################################
    // pulses and bus response
    // ########################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_o     <= 1'b0;
            cmd_valid_q <= 1'b0;
            ready_q     <= 1'b0;
        end else begin
            start_o     <= wr_en && (bus_i.addr == feeder_map_pkg::REG_TR) && bus_i.wdata[0];
            cmd_valid_q <= wr_en && (bus_i.addr == feeder_map_pkg::REG_CMD);
            ready_q     <= bus_i.strobe;
        end
    end

    // direct command with the data word in the upper half and the config index
    always_ff @(posedge clk_i) begin
        if (wr_en && (bus_i.addr == feeder_map_pkg::REG_CMD)) begin
            cmd_op_q <= feeder_types_pkg::tpu_op_e'(bus_i.wdata[7:0]);
            cmd_p1_q <= bus_i.wdata[XW-1 -: WW];
            cmd_p2_q <= WW'(cfg_q.idx);
        end
    end

    // only the busy flag reads back and other addresses return 0
    always_ff @(posedge clk_i) begin
        if (rd_en && (bus_i.addr == feeder_map_pkg::REG_BUSY)) begin
            rdata_q <= XW'(busy);
        end else begin
            rdata_q <= '0;
        end
    end

    assign direct_cmd_o.valid   = cmd_valid_q;
    assign direct_cmd_o.op      = cmd_op_q;
    assign direct_cmd_o.param_1 = cmd_p1_q;
    assign direct_cmd_o.param_2 = cmd_p2_q;

    assign bus_o.ready = ready_q;
    assign bus_o.rdata = rdata_q;

    // a start with a nonzero length takes both engines out of idle
    a_start_wakes_engines: assert property (
        @(posedge clk_i) disable iff (rst_i)
        start_o && (cfg_q.len[LEN_BITS-1:0] != '0) |=> req_busy_i && load_busy_i
    );

endmodule

`default_nettype wire

/* hw/feeder_types_pkg.sv */
`default_nettype none

package feeder_types_pkg;

    // length and index fields of the transfer config
    localparam int CFG_FIELD_W = 16;

    // ########################################
    // encodings
    // ########################################

    // other opcodes pass through on direct writes
    typedef enum logic [7:0] {
        OP_LOAD_INPUT  = 8'd9,
        OP_LOAD_WEIGHT = 8'd10
    } tpu_op_e;

    typedef enum logic {
        KIND_INPUT  = 1'b0,
        KIND_WEIGHT = 1'b1
    } word_kind_e;

    typedef enum logic [1:0] {
        REQ_IDLE,
        REQ_WAIT,
        REQ_SEND
    } req_state_e;

    typedef enum logic [1:0] {
        LD_IDLE,
        LD_WAIT_LINE,
        LD_EMIT,
        LD_POP
    } load_state_e;

    // ########################################
    // bundles
    // ########################################

    typedef struct packed {
        logic                            strobe;
        // high for write
        logic                            rw;
        logic [feeder_map_pkg::XLEN-1:0] addr;
        logic [feeder_map_pkg::XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic                            ready;
        logic [feeder_map_pkg::XLEN-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [feeder_map_pkg::XLEN-1:0] addr;
        logic [CFG_FIELD_W-1:0]          len;
        word_kind_e                      kind;
        logic [CFG_FIELD_W-1:0]          idx;
    } xfer_cfg_t;

    typedef struct packed {
        logic                              valid;
        tpu_op_e                           op;
        logic [feeder_map_pkg::WORD_W-1:0] param_1;
        logic [feeder_map_pkg::WORD_W-1:0] param_2;
    } tpu_cmd_t;

endpackage

`default_nettype wire

/* hw/feeder_map_pkg.sv */
`default_nettype none

package feeder_map_pkg;

    // ########################################
    // processor bus
    // ########################################

    localparam int XLEN = 32;

    // each register is one 32-bit word
    localparam logic [XLEN-1:0] REG_CMD      = 32'hC400_0000;
    localparam logic [XLEN-1:0] REG_BUSY     = 32'hC400_0020;

    // load transfer setup
    localparam logic [XLEN-1:0] REG_RD_ADDR  = 32'hC400_2024;
    localparam logic [XLEN-1:0] REG_RD_LEN   = 32'hC400_2028;
    localparam logic [XLEN-1:0] REG_TR       = 32'hC400_2030;
    localparam logic [XLEN-1:0] REG_SRAM_IDX = 32'hC400_2034;
    localparam logic [XLEN-1:0] REG_KIND     = 32'hC400_2038;

    // ########################################
    // line and word geometry
    // ########################################

    // accelerator word
    localparam int WORD_W     = 16;

    // one DRAM line
    localparam int LINE_BYTES = 64;
    localparam int LINE_WORDS = LINE_BYTES / (WORD_W / 8);
    localparam int LINE_W     = LINE_BYTES * 8;

    // byte offset bits inside a line
    localparam int LINE_OFS_W = $clog2(LINE_BYTES);

    // word select bits, byte address bits 5:1
    localparam int WORD_SEL_W = $clog2(LINE_WORDS);

endpackage

`default_nettype wire
